// File: source/busPkg.sv
package busPkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = DATA_W / 8; // One enable per byte lane.

    localparam int SLV_ROM = 0;
    localparam int SLV_RAM = 1;

    // Instruction fetch request.
    typedef struct packed {
        logic              rd;
        logic [ADDR_W-1:0] addr;
    } t_InstrReq;

    // Load/store request.
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [BE_W-1:0]   be;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } t_DataReq;

    // Response, valid one cycle after the request.
    typedef struct packed {
        logic              done;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } t_BusRsp;

endpackage

// File: source/bootRom.sv
`timescale 1ns/10ps

module bootRom import busPkg::*; #(
    parameter int ADDR_SEL_BITS = 6,
    parameter int DEPTH         = 64
) (
    input  logic                            i_Clk,
    input  logic                            i_rstN,

    input  logic                            i_Sel0,
    input  logic                            i_Rd0,
    input  logic [ADDR_W-ADDR_SEL_BITS-3:0] i_Addr0,
    output logic [DATA_W-1:0]               o_RdData0,

    input  logic                            i_Sel1,
    input  logic                            i_Rd1,
    input  logic [ADDR_W-ADDR_SEL_BITS-3:0] i_Addr1,
    output logic [DATA_W-1:0]               o_RdData1
);

    localparam int IDX_W     = $clog2(DEPTH);
    localparam int IMG_WORDS = 60;

    // Boot program followed by its constant table and string.
    localparam logic [DATA_W-1:0] IMAGE [IMG_WORDS] = '{
        32'h19008137, 32'h7fc10113, 32'h00000317, 32'h0b830313,
        32'h00032403, 32'h00432483, 32'h00c32903, 32'h01032983,
        32'h01432a03, 32'h01832a83, 32'h010f12b7, 32'hf0f28293,
        32'h005a2623, 32'habcdf537, 32'hf1250513, 32'h00000593,
        32'h00048613, 32'h014000ef, 32'h00048513, 32'h03c000ef,
        32'h00000493, 32'h0000006f, 32'h10000293, 32'h00562023,
        32'h00b62223, 32'h00400293, 32'h00000313, 32'h00a62423,
        32'h00855513, 32'h00130313, 32'hfe629ae3, 32'h10400293,
        32'h00562023, 32'h00008067, 32'h00150283, 32'h0022f293,
        32'hfe029ce3, 32'h00100293, 32'h00552223, 32'h10600293,
        32'h00552023, 32'h00150283, 32'h0022f293, 32'hfe029ce3,
        32'h00850283, 32'h0012f293, 32'hfe0292e3, 32'h00008067,
        32'h18000000, 32'h19000000, 32'h19008000, 32'h1900c000,
        32'h19020000, 32'h19024000, 32'h06800000, 32'h047868c0,
        32'h6c6c6548, 32'h6f57206f, 32'h0d646c72, 32'h0000000a
    };

    logic [DATA_W-1:0] rom [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            if (i < IMG_WORDS) begin
                rom[i] = IMAGE[i];
            end else begin
                rom[i] = '0; // Unused words read as zero.
            end
        end
    end

    function automatic logic [DATA_W-1:0] readPort(input logic sel, input logic rd,
                                                   input logic [IDX_W-1:0] idx);
        if (sel && rd) begin
            return rom[idx];
        end
        return '0;
    endfunction

    // Both ports read the same array independently.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_RdData0 <= '0;
            o_RdData1 <= '0;
        end else begin
            o_RdData0 <= readPort(i_Sel0, i_Rd0, i_Addr0[IDX_W-1:0]);
            o_RdData1 <= readPort(i_Sel1, i_Rd1, i_Addr1[IDX_W-1:0]);
        end
    end

    a_port0InRange: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        (i_Sel0 && i_Rd0) |-> (i_Addr0 < DEPTH));
    a_port1InRange: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        (i_Sel1 && i_Rd1) |-> (i_Addr1 < DEPTH));

endmodule

// File: source/dataRam.sv
`timescale 1ns/10ps

module dataRam import busPkg::*; #(
    parameter int ADDR_SEL_BITS = 6,
    parameter int DEPTH         = 256
) (
    input  logic                            i_Clk,
    input  logic                            i_rstN,
    input  logic                            i_Sel,
    input  logic                            i_Rd,
    input  logic                            i_Wr,
    input  logic [BE_W-1:0]                 i_Be,
    input  logic [ADDR_W-ADDR_SEL_BITS-3:0] i_Addr,
    input  logic [DATA_W-1:0]               i_WrData,
    output logic [DATA_W-1:0]               o_RdData
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  wordIdx;

    assign wordIdx = i_Addr[IDX_W-1:0];

    // Byte lanes without an enable keep their old value.
    always_ff @(posedge i_Clk) begin
        if (i_Sel && i_Wr) begin
            for (int b = 0; b < BE_W; b++) begin
                if (i_Be[b]) begin
                    mem[wordIdx][8*b +: 8] <= i_WrData[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_RdData <= '0;
        end else if (i_Sel && i_Rd) begin
            o_RdData <= mem[wordIdx];
        end else begin
            o_RdData <= '0; // Idle cycles return zero.
        end
    end

    a_noRdWr: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        !(i_Rd && i_Wr));

    // Upper word address bits would alias onto low words.
    a_inRange: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        (i_Sel && (i_Rd || i_Wr)) |-> (i_Addr < DEPTH));

endmodule

// File: source/addrDecoder.sv
`timescale 1ns/10ps

module addrDecoder import busPkg::*; #(
    parameter int ADDR_SEL_BITS = 6,
    parameter bit HAS_RAM       = 1'b1
) (
    input  logic                            i_Clk,
    input  logic                            i_rstN,
    input  logic                            i_Rd,
    input  logic                            i_Wr,
    input  logic [ADDR_W-1:0]               i_Addr,
    output logic                            o_RomSel,
    output logic                            o_RamSel,
    output logic [ADDR_W-ADDR_SEL_BITS-3:0] o_WordAddr,
    input  logic [DATA_W-1:0]               i_RomData,
    input  logic [DATA_W-1:0]               i_RamData,
    output t_BusRsp                         o_Rsp
);

    // What the response cycle needs to know about the request.
    typedef struct packed {
        logic done;
        logic err;
        logic fromRom;
        logic fromRam;
    } t_RspState;

    logic [ADDR_SEL_BITS-1:0] slvNum;
    logic                     access;
    logic                     romHit;
    logic                     ramHit;
    logic                     legal;
    t_RspState                rspState;

    assign slvNum     = i_Addr[ADDR_W-1 -: ADDR_SEL_BITS];
    assign o_WordAddr = i_Addr[ADDR_W-ADDR_SEL_BITS-1:2]; // Drop byte offset.
    assign access     = i_Rd | i_Wr;

    assign romHit = (slvNum == ADDR_SEL_BITS'(SLV_ROM));
    assign ramHit = HAS_RAM && (slvNum == ADDR_SEL_BITS'(SLV_RAM));
    assign legal  = romHit ? !i_Wr : ramHit; // ROM is read only.

    assign o_RomSel = access & romHit;
    assign o_RamSel = access & ramHit;

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            rspState <= '0;
        end else begin
            rspState.done    <= access;
            rspState.err     <= access & ~legal;
            rspState.fromRom <= i_Rd & romHit;
            rspState.fromRam <= i_Rd & ramHit;
        end
    end

    always_comb begin
        o_Rsp.done = rspState.done;
        o_Rsp.err  = rspState.err;
        if (rspState.fromRom) begin
            o_Rsp.rdata = i_RomData;
        end else if (rspState.fromRam) begin
            o_Rsp.rdata = i_RamData;
        end else begin
            o_Rsp.rdata = '0;
        end
    end

    // ROM port must stay quiet unless this master read it.
    a_romQuiet: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        !rspState.fromRom |-> (i_RomData == '0));

endmodule

// File: source/socBus.sv
`timescale 1ns/10ps

module socBus import busPkg::*; #(
    parameter int ADDR_SEL_BITS = 6,
    parameter int ROM_DEPTH     = 64,
    parameter int RAM_DEPTH     = 256
) (
    input  logic      i_Clk,
    input  logic      i_rstN,
    input  t_InstrReq i_IReq,
    input  t_DataReq  i_DReq,
    output t_BusRsp   o_IRsp,
    output t_BusRsp   o_DRsp
);

    localparam int WA_W = ADDR_W - ADDR_SEL_BITS - 2;

    logic              iRomSel;
    logic [WA_W-1:0]   iWordAddr;
    logic [DATA_W-1:0] iRomData;

    logic              dRomSel;
    logic              dRamSel;
    logic [WA_W-1:0]   dWordAddr;
    logic [DATA_W-1:0] dRomData;
    logic [DATA_W-1:0] dRamData;

    // Instruction side, ROM only.
    addrDecoder #(
        .ADDR_SEL_BITS(ADDR_SEL_BITS),
        .HAS_RAM      (1'b0)
    ) iDec (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_Rd      (i_IReq.rd),
        .i_Wr      (1'b0),        // Fetch port never writes.
        .i_Addr    (i_IReq.addr),
        .o_RomSel  (iRomSel),
        .o_RamSel  (),
        .o_WordAddr(iWordAddr),
        .i_RomData (iRomData),
        .i_RamData ('0),
        .o_Rsp     (o_IRsp)
    );

    addrDecoder #(
        .ADDR_SEL_BITS(ADDR_SEL_BITS),
        .HAS_RAM      (1'b1)
    ) dDec (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_Rd      (i_DReq.rd),
        .i_Wr      (i_DReq.wr),
        .i_Addr    (i_DReq.addr),
        .o_RomSel  (dRomSel),
        .o_RamSel  (dRamSel),
        .o_WordAddr(dWordAddr),
        .i_RomData (dRomData),
        .i_RamData (dRamData),
        .o_Rsp     (o_DRsp)
    );

    bootRom #(
        .ADDR_SEL_BITS(ADDR_SEL_BITS),
        .DEPTH        (ROM_DEPTH)
    ) rom (
        .i_Clk    (i_Clk),
        .i_rstN   (i_rstN),
        .i_Sel0   (iRomSel),
        .i_Rd0    (i_IReq.rd),
        .i_Addr0  (iWordAddr),
        .o_RdData0(iRomData),
        .i_Sel1   (dRomSel),
        .i_Rd1    (i_DReq.rd),
        .i_Addr1  (dWordAddr),
        .o_RdData1(dRomData)
    );

    dataRam #(
        .ADDR_SEL_BITS(ADDR_SEL_BITS),
        .DEPTH        (RAM_DEPTH)
    ) ram (
        .i_Clk   (i_Clk),
        .i_rstN  (i_rstN),
        .i_Sel   (dRamSel),
        .i_Rd    (i_DReq.rd),
        .i_Wr    (i_DReq.wr),
        .i_Be    (i_DReq.be),
        .i_Addr  (dWordAddr),
        .i_WrData(i_DReq.wdata),
        .o_RdData(dRamData)
    );

endmodule

// File: verif/socBusTb.sv
`timescale 1ns/10ps

module socBusTb import busPkg::*; ();

    localparam string GOLDEN_FILE = "verif/socBus_golden.txt";
    localparam int    MAX_LINES   = 128;
    localparam int    CLK_PERIOD  = 100;

    logic      i_Clk;
    logic      i_rstN;
    t_InstrReq iReq;
    t_DataReq  dReq;
    t_BusRsp   iRsp;
    t_BusRsp   dRsp;

    // Golden transactions, one entry per data line of the file.
    logic [7:0]        joinArr [MAX_LINES];
    logic [7:0]        portArr [MAX_LINES];
    logic [7:0]        opArr   [MAX_LINES];
    logic [ADDR_W-1:0] addrArr [MAX_LINES];
    logic [DATA_W-1:0] wdataArr[MAX_LINES];
    logic [BE_W-1:0]   beArr   [MAX_LINES];
    logic [DATA_W-1:0] dataArr [MAX_LINES];
    logic              errArr  [MAX_LINES];
    int                srcLine [MAX_LINES];
    int                numLines;
    bit                loaded;

    t_BusRsp expI;
    t_BusRsp expD;
    int      lineI;
    int      lineD;

    socBus #(
        .ADDR_SEL_BITS(6),
        .ROM_DEPTH    (64),
        .RAM_DEPTH    (256)
    ) UUT (
        .i_Clk (i_Clk),
        .i_rstN(i_rstN),
        .i_IReq(iReq),
        .i_DReq(dReq),
        .o_IRsp(iRsp),
        .o_DRsp(dRsp)
    );

    initial i_Clk = 1'b0;
    always #(CLK_PERIOD / 2) i_Clk = ~i_Clk;

    task automatic checkVal(input string name, input logic [DATA_W-1:0] expVal,
                            input logic [DATA_W-1:0] actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s: expected %h, actual %h", name, expVal, actVal);
            $display("Simulation failed");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic stopOnError(input string reason);
        $display("Error: %s", reason);
        $display("Simulation failed");
        $fatal(1, "testbench stopped");
    endtask

    task automatic loadGolden();
        int               fd;
        int               n;
        int               lineNo;
        string            line;
        logic [7:0]       joinCh;
        logic [7:0]       portCh;
        logic [7:0]       opCh;
        logic [31:0]      addrIn;
        logic [31:0]      wdataIn;
        logic [3:0]       beIn;
        logic [31:0]      dataIn;
        logic [3:0]       errIn;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            stopOnError({"cannot open ", GOLDEN_FILE});
        end
        lineNo = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            lineNo++;
            if (n == 0 || line[0] == "#" || line[0] == "\n") begin
                continue; // Comment or blank line.
            end
            n = $sscanf(line, "%c %c %c %h %h %h %h %h", joinCh, portCh, opCh,
                        addrIn, wdataIn, beIn, dataIn, errIn);
            if (n != 8) begin
                stopOnError($sformatf("golden file line %0d is malformed", lineNo));
            end
            if (numLines >= MAX_LINES) begin
                stopOnError("golden file has too many lines");
            end
            joinArr[numLines]  = joinCh;
            portArr[numLines]  = portCh;
            opArr[numLines]    = opCh;
            addrArr[numLines]  = addrIn;
            wdataArr[numLines] = wdataIn;
            beArr[numLines]    = beIn;
            dataArr[numLines]  = dataIn;
            errArr[numLines]   = errIn[0];
            srcLine[numLines]  = lineNo;
            numLines++;
        end
        $fclose(fd);
    endtask

    task automatic clearRequests();
        iReq = '0;
        dReq = '0;
        expI = '0; // A port without a request must stay all zero.
        expD = '0;
    endtask

    // Drives one golden line and records what its port should answer.
    task automatic applyLine(input int k);
        t_BusRsp rsp;
        rsp.done  = (opArr[k] != "N");
        rsp.err   = errArr[k];
        rsp.rdata = dataArr[k];
        if (portArr[k] == "I") begin
            if (opArr[k] == "R") begin
                iReq.rd   = 1'b1;
                iReq.addr = addrArr[k];
            end else if (opArr[k] != "N") begin
                stopOnError($sformatf("line %0d: the instruction port only reads", srcLine[k]));
            end
            expI  = rsp;
            lineI = srcLine[k];
        end else begin
            dReq.rd    = (opArr[k] == "R");
            dReq.wr    = (opArr[k] == "W");
            dReq.be    = beArr[k];
            dReq.addr  = addrArr[k];
            dReq.wdata = wdataArr[k];
            expD  = rsp;
            lineD = srcLine[k];
        end
    endtask

    task automatic compareResponses();
        checkVal($sformatf("line %0d I done", lineI), DATA_W'(expI.done), DATA_W'(iRsp.done));
        checkVal($sformatf("line %0d I err", lineI), DATA_W'(expI.err), DATA_W'(iRsp.err));
        checkVal($sformatf("line %0d I rdata", lineI), expI.rdata, iRsp.rdata);
        checkVal($sformatf("line %0d D done", lineD), DATA_W'(expD.done), DATA_W'(dRsp.done));
        checkVal($sformatf("line %0d D err", lineD), DATA_W'(expD.err), DATA_W'(dRsp.err));
        checkVal($sformatf("line %0d D rdata", lineD), expD.rdata, dRsp.rdata);
    endtask

    // Watchdog sized from the number of golden lines.
    initial begin
        wait (loaded);
        #((numLines + 10) * CLK_PERIOD);
        $display("Timeout: the test did not finish within %0d clock cycles", numLines + 10);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int idx;
        int first;
        i_rstN   = 1'b0;
        iReq     = '0;
        dReq     = '0;
        expI     = '0;
        expD     = '0;
        lineI    = 0;
        lineD    = 0;
        numLines = 0;
        loaded   = 1'b0;
        loadGolden();
        loaded = 1'b1;

        repeat (3) @(posedge i_Clk);
        @(negedge i_Clk);
        i_rstN = 1'b1;
        compareResponses(); // Outputs straight out of reset.

        idx = 0;
        while (idx < numLines) begin
            clearRequests();
            first = idx;
            lineI = srcLine[idx];
            lineD = srcLine[idx];
            applyLine(idx);
            idx++;
            while (idx < numLines && joinArr[idx] == "+") begin
                if (portArr[idx] == portArr[first]) begin
                    stopOnError($sformatf("line %0d shares a cycle with its own port",
                                          srcLine[idx]));
                end
                applyLine(idx);
                idx++;
            end
            @(posedge i_Clk);
            @(negedge i_Clk);
            compareResponses();
        end

        clearRequests();
        @(posedge i_Clk);
        @(negedge i_Clk);
        compareResponses(); // Final idle cycle.

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: flist.f
source/busPkg.sv
source/bootRom.sv
source/dataRam.sv
source/addrDecoder.sv
source/socBus.sv
verif/socBusTb.sv

// File: run.sh
#!/bin/sh
# Build and run the socBus testbench with Verilator from the project root.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f flist.f \
        --top-module socBusTb -o socBusSim \
    && ./obj_dir/socBusSim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

// File: verif/socBus_golden.txt
# cyc: '.' starts a new cycle, '+' shares the cycle above; op: R read, W write, N none
# cyc port op addr wdata be exp_rdata exp_err (hex)
. I N 00000000 00000000 0 00000000 0
. I R 00000000 00000000 0 19008137 0
. I R 00000004 00000000 0 7fc10113 0
. I R 00000084 00000000 0 00008067 0
. I R 000000ec 00000000 0 0000000a 0
. D R 00000000 00000000 0 19008137 0
. D R 00000030 00000000 0 005a2623 0
. D R 000000e0 00000000 0 6c6c6548 0
. D R 000000f0 00000000 0 00000000 0
. D R 000000fc 00000000 0 00000000 0
. I N 00000000 00000000 0 00000000 0
. D W 04000000 11223344 f 00000000 0
. D R 04000000 00000000 0 11223344 0
. D W 04000000 aabbccdd 1 00000000 0
. D R 04000000 00000000 0 112233dd 0
. D W 04000000 aabbccdd 6 00000000 0
. D R 04000000 00000000 0 11bbccdd 0
. D W 04000000 eeeeeeee 8 00000000 0
. D R 04000000 00000000 0 eebbccdd 0
. D W 04000000 55555555 0 00000000 0
. D R 04000000 00000000 0 eebbccdd 0
. D W 04000014 deadbeef f 00000000 0
. D W 04000014 01020304 c 00000000 0
. D R 04000014 00000000 0 0102beef 0
. D W 040003fc cafef00d f 00000000 0
. D W 040003fc 12345678 5 00000000 0
. D R 040003fc 00000000 0 ca34f078 0
. D R 04000000 00000000 0 eebbccdd 0
. D W 04000004 0f0f0f0f f 00000000 0
. D W 04000004 00000000 3 00000000 0
. D R 04000004 00000000 0 0f0f0000 0
. I R 00000008 00000000 0 00000317 0
+ D R 00000008 00000000 0 00000317 0
. I R 00000010 00000000 0 00032403 0
+ D R 000000c8 00000000 0 19008000 0
. I R 000000d4 00000000 0 19024000 0
+ D R 04000014 00000000 0 0102beef 0
. I R 0000002c 00000000 0 f0f28293 0
+ D W 04000008 76543210 f 00000000 0
. I R 00000040 00000000 0 00048613 0
+ D R 04000008 00000000 0 76543210 0
. I R 000000dc 00000000 0 047868c0 0
+ D R 000000dc 00000000 0 047868c0 0
. D R 000000d8 00000000 0 06800000 0
+ I R 00000044 00000000 0 014000ef 0
. I R 08000000 00000000 0 00000000 1
. D R 08000000 00000000 0 00000000 1
. D W 0c000010 12345678 f 00000000 1
. I R fc000000 00000000 0 00000000 1
. D R fc000004 00000000 0 00000000 1
. I R 04000000 00000000 0 00000000 1
. D W 00000000 ffffffff f 00000000 1
. D W 00000084 12345678 f 00000000 1
. D R 00000000 00000000 0 19008137 0
. I R 00000084 00000000 0 00008067 0
+ D R 00000084 00000000 0 00008067 0
. I R 40000000 00000000 0 00000000 1
+ D W 00000004 00000000 f 00000000 1
. I R 00000004 00000000 0 7fc10113 0
. D R 04000000 00000000 0 eebbccdd 0
. I N 00000000 00000000 0 00000000 0
. D N 00000000 00000000 0 00000000 0
